//--- sim.f
source/mipsPkg.sv
source/controlDecoder.sv
source/nextPcUnit.sv
source/aluExecute.sv
source/registerFile.sv
source/mipsCpuHarvard.sv
test/harvardMemModel.sv
test/mipsCpuTb.sv

//--- source/aluExecute.sv
/*
  Execute stage: ALU with immediate extension and shifts,
  beq/bne condition, HI/LO registers loaded by multu
*/
`default_nettype none

module aluExecute import mipsPkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  logic        clkEnable,
  input  instrWord    instr,
  input  aluOpT       aluOp,
  input  logic        useImmediate,
  input  logic        signExtend,
  input  logic        hiLoWrite,
  input  logic        branchOnEqual,
  input  logic [31:0] rsData,
  input  logic [31:0] rtData,
  output logic [31:0] aluResult,
  output logic        branchTaken
);

  logic [31:0] immExtended;
  logic [31:0] operandB;
  logic [63:0] product;
  logic [31:0] hi;
  logic [31:0] lo;
  logic        operandsEqual;

  // andi and ori take a zero-extended immediate
  assign immExtended = signExtend
    ? {{16{instr.iFormat.immediate[15]}}, instr.iFormat.immediate}
    : {16'd0, instr.iFormat.immediate};

  assign operandB = useImmediate ? immExtended : rtData;

  always_comb
  begin
    case (aluOp)
      aluAdd:  aluResult = rsData + operandB;
      aluSub:  aluResult = rsData - operandB;
      aluAnd:  aluResult = rsData & operandB;
      aluOr:   aluResult = rsData | operandB;
      aluXor:  aluResult = rsData ^ operandB;
      aluSlt:  aluResult = {31'd0, $signed(rsData) < $signed(operandB)};
      aluSltu: aluResult = {31'd0, rsData < operandB};
      // Shifts move rt by shamt
      aluSll:  aluResult = rtData << instr.rFormat.shamt;
      aluSrl:  aluResult = rtData >> instr.rFormat.shamt;
      aluLui:  aluResult = {instr.iFormat.immediate, 16'd0};
      aluMfhi: aluResult = hi;
      aluMflo: aluResult = lo;
      default: aluResult = 32'd0;
    endcase
  end

  // Branch condition
  assign operandsEqual = (rsData == rtData);
  assign branchTaken   = branchOnEqual ? operandsEqual : !operandsEqual;

  // Unsigned 32x32 product
  assign product = {32'd0, rsData} * {32'd0, rtData};

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      hi <= 32'd0;
      lo <= 32'd0;
    end
    else if (clkEnable && hiLoWrite)
    begin
      hi <= product[63:32];
      lo <= product[31:0];
    end
  end

endmodule

`default_nettype wire

//--- source/controlDecoder.sv
/*
  Main control decoder: opcode and funct to datapath controls,
  with the write and memory strobes held low while the core
  is not active
*/
`default_nettype none

module controlDecoder import mipsPkg::*; (
  input  instrWord   instr,
  input  logic       active,
  output aluOpT      aluOp,
  output logic       useImmediate,
  output logic       signExtend,
  output regDstT     regDst,
  output wbSelT      wbSel,
  output logic       regWrite,
  output logic       hiLoWrite,
  output logic       branch,
  output logic       branchOnEqual,
  output logic       jump,
  output logic       jumpReg,
  output logic       dataRead,
  output logic       dataWrite
);

  // Strobes before the active gate
  logic regWriteDec;
  logic hiLoWriteDec;
  logic dataReadDec;
  logic dataWriteDec;

  always_comb
  begin
    // Defaults give a no-operation
    aluOp         = aluAdd;
    useImmediate  = 1'b0;
    signExtend    = 1'b0;
    regDst        = dstRt;
    wbSel         = wbAlu;
    regWriteDec   = 1'b0;
    hiLoWriteDec  = 1'b0;
    branch        = 1'b0;
    branchOnEqual = 1'b0;
    jump          = 1'b0;
    jumpReg       = 1'b0;
    dataReadDec   = 1'b0;
    dataWriteDec  = 1'b0;
    case (instr.rFormat.opcode)
      opSpecial:
      begin
        regDst      = dstRd;
        regWriteDec = 1'b1;
        case (instr.rFormat.funct)
          fnAddu:  aluOp = aluAdd;
          fnSubu:  aluOp = aluSub;
          fnAnd:   aluOp = aluAnd;
          fnOr:    aluOp = aluOr;
          fnXor:   aluOp = aluXor;
          fnSlt:   aluOp = aluSlt;
          fnSltu:  aluOp = aluSltu;
          fnSll:   aluOp = aluSll;
          fnSrl:   aluOp = aluSrl;
          fnMfhi:  aluOp = aluMfhi;
          fnMflo:  aluOp = aluMflo;
          fnJr:
          begin
            jumpReg     = 1'b1;
            regWriteDec = 1'b0;
          end
          fnMultu:
          begin
            // Product goes to HI/LO only
            hiLoWriteDec = 1'b1;
            regWriteDec  = 1'b0;
          end
          default: regWriteDec = 1'b0;
        endcase
      end
      opAddiu:
      begin
        useImmediate = 1'b1;
        signExtend   = 1'b1;
        regWriteDec  = 1'b1;
      end
      opSlti:
      begin
        aluOp        = aluSlt;
        useImmediate = 1'b1;
        signExtend   = 1'b1;
        regWriteDec  = 1'b1;
      end
      opAndi:
      begin
        aluOp        = aluAnd;
        useImmediate = 1'b1;
        regWriteDec  = 1'b1;
      end
      opOri:
      begin
        aluOp        = aluOr;
        useImmediate = 1'b1;
        regWriteDec  = 1'b1;
      end
      opLui:
      begin
        aluOp       = aluLui;
        regWriteDec = 1'b1;
      end
      opLw:
      begin
        // Address is rs plus offset
        useImmediate = 1'b1;
        signExtend   = 1'b1;
        wbSel        = wbMemory;
        regWriteDec  = 1'b1;
        dataReadDec  = 1'b1;
      end
      opSw:
      begin
        useImmediate = 1'b1;
        signExtend   = 1'b1;
        dataWriteDec = 1'b1;
      end
      opBeq:
      begin
        branch        = 1'b1;
        branchOnEqual = 1'b1;
      end
      opBne:   branch = 1'b1;
      opJ:     jump = 1'b1;
      opJal:
      begin
        // No delay slot, link is PC+4
        jump        = 1'b1;
        regDst      = dstRa;
        wbSel       = wbLink;
        regWriteDec = 1'b1;
      end
      default: ;
    endcase
  end

  // Halted core commits nothing
  assign regWrite  = regWriteDec & active;
  assign hiLoWrite = hiLoWriteDec & active;
  assign dataRead  = dataReadDec & active;
  assign dataWrite = dataWriteDec & active;

endmodule

`default_nettype wire

//--- source/mipsCpuHarvard.sv
/*
  Single-cycle MIPS32 core, Harvard bus interface:
  decoder, PC unit, ALU and register file
*/
`default_nettype none

module mipsCpuHarvard import mipsPkg::*; #(
  parameter logic [31:0] resetVector = defaultResetVector
) (
  input  logic        clk,
  input  logic        reset,
  input  logic        clkEnable,
  output logic [31:0] instrAddress,
  input  logic [31:0] instrReaddata,
  output logic [31:0] dataAddress,
  output logic        dataRead,
  output logic        dataWrite,
  output logic [31:0] dataWritedata,
  input  logic [31:0] dataReaddata,
  output logic        active,
  output logic [31:0] registerV0
);

  // Decoded controls
  aluOpT  aluOp;
  regDstT regDst;
  wbSelT  wbSel;
  logic   useImmediate;
  logic   signExtend;
  logic   regWrite;
  logic   hiLoWrite;
  logic   branch;
  logic   branchOnEqual;
  logic   jump;
  logic   jumpReg;

  // Datapath
  logic        branchTaken;
  logic [31:0] rsData;
  logic [31:0] linkAddress;

  controlDecoder controlDecoder_inst (
    .instr         (instrReaddata),
    .active        (active),
    .aluOp         (aluOp),
    .useImmediate  (useImmediate),
    .signExtend    (signExtend),
    .regDst        (regDst),
    .wbSel         (wbSel),
    .regWrite      (regWrite),
    .hiLoWrite     (hiLoWrite),
    .branch        (branch),
    .branchOnEqual (branchOnEqual),
    .jump          (jump),
    .jumpReg       (jumpReg),
    .dataRead      (dataRead),
    .dataWrite     (dataWrite)
  );

  // PC drives the instruction bus directly
  nextPcUnit #(
    .resetVector (resetVector)
  ) nextPcUnit_inst (
    .clk         (clk),
    .reset       (reset),
    .clkEnable   (clkEnable),
    .instr       (instrReaddata),
    .branch      (branch),
    .branchTaken (branchTaken),
    .jump        (jump),
    .jumpReg     (jumpReg),
    .rsData      (rsData),
    .pc          (instrAddress),
    .linkAddress (linkAddress),
    .active      (active)
  );

  // ALU result doubles as the data address
  aluExecute aluExecute_inst (
    .clk           (clk),
    .reset         (reset),
    .clkEnable     (clkEnable),
    .instr         (instrReaddata),
    .aluOp         (aluOp),
    .useImmediate  (useImmediate),
    .signExtend    (signExtend),
    .hiLoWrite     (hiLoWrite),
    .branchOnEqual (branchOnEqual),
    .rsData        (rsData),
    .rtData        (dataWritedata),
    .aluResult     (dataAddress),
    .branchTaken   (branchTaken)
  );

  // rt read port is the store data
  registerFile registerFile_inst (
    .clk          (clk),
    .reset        (reset),
    .clkEnable    (clkEnable),
    .instr        (instrReaddata),
    .regDst       (regDst),
    .wbSel        (wbSel),
    .regWrite     (regWrite),
    .aluResult    (dataAddress),
    .dataReaddata (dataReaddata),
    .linkAddress  (linkAddress),
    .rsData       (rsData),
    .rtData       (dataWritedata),
    .registerV0   (registerV0)
  );

endmodule

`default_nettype wire

//--- source/mipsPkg.sv
/*
  Shared MIPS32 definitions for the single-cycle core:
  opcode and function code enums, the instruction word union
  with R, I and J views, ALU operation, write-back source and
  destination register enums, default reset vector
*/
`default_nettype none

package mipsPkg;

  // Boot address used when the top level is not overridden
  localparam logic [31:0] defaultResetVector = 32'hBFC00000;

  // Supported primary opcodes, special selects the R-type group
  typedef enum logic [5:0] {
    opSpecial = 6'h00,
    opJ       = 6'h02,
    opJal     = 6'h03,
    opBeq     = 6'h04,
    opBne     = 6'h05,
    opAddiu   = 6'h09,
    opSlti    = 6'h0A,
    opAndi    = 6'h0C,
    opOri     = 6'h0D,
    opLui     = 6'h0F,
    opLw      = 6'h23,
    opSw      = 6'h2B
  } opcodeT;

  // Supported R-type function codes
  typedef enum logic [5:0] {
    fnSll   = 6'h00,
    fnSrl   = 6'h02,
    fnJr    = 6'h08,
    fnMfhi  = 6'h10,
    fnMflo  = 6'h12,
    fnMultu = 6'h19,
    fnAddu  = 6'h21,
    fnSubu  = 6'h23,
    fnAnd   = 6'h24,
    fnOr    = 6'h25,
    fnXor   = 6'h26,
    fnSlt   = 6'h2A,
    fnSltu  = 6'h2B
  } functT;

  // Register-register layout
  typedef struct packed {
    opcodeT     opcode;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    logic [4:0] shamt;
    functT      funct;
  } rFormatT;

  // Immediate layout, shared by loads, stores and branches
  typedef struct packed {
    opcodeT      opcode;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [15:0] immediate;
  } iFormatT;

  // Jump layout, 26-bit word target
  typedef struct packed {
    opcodeT      opcode;
    logic [25:0] target;
  } jFormatT;

  // One fetched word, three ways to read it
  typedef union packed {
    rFormatT rFormat;
    iFormatT iFormat;
    jFormatT jFormat;
  } instrWord;

  typedef enum logic [3:0] {
    aluAdd, aluSub, aluAnd, aluOr, aluXor, aluSlt, aluSltu,
    aluSll, aluSrl, aluLui, aluMfhi, aluMflo
  } aluOpT;

  // Write-back value source
  typedef enum logic [1:0] {
    wbAlu, wbMemory, wbLink
  } wbSelT;

  // Destination register choice, dstRa is register 31
  typedef enum logic [1:0] {
    dstRt, dstRd, dstRa
  } regDstT;

endpackage

`default_nettype wire

//--- source/nextPcUnit.sv
/*
  Program counter and active flag, next PC selection
  between register, jump, branch and sequential targets,
  link address output
*/
`default_nettype none

module nextPcUnit import mipsPkg::*; #(
  parameter logic [31:0] resetVector = defaultResetVector
) (
  input  logic        clk,
  input  logic        reset,
  input  logic        clkEnable,
  input  instrWord    instr,
  input  logic        branch,
  input  logic        branchTaken,
  input  logic        jump,
  input  logic        jumpReg,
  input  logic [31:0] rsData,
  output logic [31:0] pc,
  output logic [31:0] linkAddress,
  output logic        active
);

  logic [31:0] pcPlus4;
  logic [31:0] branchOffset;
  logic [31:0] jumpTarget;
  logic [31:0] nextPc;

  assign pcPlus4     = pc + 32'd4;
  assign linkAddress = pcPlus4;

  // Word offset, sign-extended
  assign branchOffset = {{14{instr.iFormat.immediate[15]}}, instr.iFormat.immediate, 2'b00};

  // Region bits come from PC+4
  assign jumpTarget = {pcPlus4[31:28], instr.jFormat.target, 2'b00};

  always_comb
  begin
    if (jumpReg)
      nextPc = rsData;
    else if (jump)
      nextPc = jumpTarget;
    else if (branch && branchTaken)
      nextPc = pcPlus4 + branchOffset;
    else
      nextPc = pcPlus4;
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      pc     <= resetVector;
      active <= 1'b1;
    end
    else if (clkEnable && active)
    begin
      pc <= nextPc;
      // Reaching address 0 halts the core
      if (nextPc == 32'd0)
        active <= 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- source/registerFile.sv
/*
  General register file: 32 x 32 bits, two combinational
  read ports, one clocked write port with destination and
  write-back source selection, v0 monitor output
*/
`default_nettype none

module registerFile import mipsPkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  logic        clkEnable,
  input  instrWord    instr,
  input  regDstT      regDst,
  input  wbSelT       wbSel,
  input  logic        regWrite,
  input  logic [31:0] aluResult,
  input  logic [31:0] dataReaddata,
  input  logic [31:0] linkAddress,
  output logic [31:0] rsData,
  output logic [31:0] rtData,
  output logic [31:0] registerV0
);

  logic [31:0] regs [32];
  logic [4:0]  destReg;
  logic [31:0] writeData;

  // Destination register
  always_comb
  begin
    case (regDst)
      dstRd:   destReg = instr.rFormat.rd;
      dstRa:   destReg = 5'd31;
      default: destReg = instr.rFormat.rt;
    endcase
  end

  // Write-back source
  always_comb
  begin
    case (wbSel)
      wbMemory: writeData = dataReaddata;
      wbLink:   writeData = linkAddress;
      default:  writeData = aluResult;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      for (int i = 0; i < 32; i++)
        regs[i] <= 32'd0;
    end
    else if (clkEnable && regWrite && destReg != 5'd0)
    begin
      // $zero is never written
      regs[destReg] <= writeData;
    end
  end

  assign rsData     = regs[instr.rFormat.rs];
  assign rtData     = regs[instr.rFormat.rt];
  assign registerV0 = regs[2];

endmodule

`default_nettype wire

//--- test/harvardMemModel.sv
/*
  Testbench memory for the Harvard core:
  instruction and data word arrays, combinational reads,
  clocked data write with write and read strobe counters,
  clear task
*/
`default_nettype none

module harvardMemModel (
  input  logic        clk,
  input  logic        reset,
  input  logic        clkEnable,
  input  logic [31:0] instrAddress,
  output logic [31:0] instrReaddata,
  input  logic [31:0] dataAddress,
  input  logic        dataRead,
  input  logic        dataWrite,
  input  logic [31:0] dataWritedata,
  output logic [31:0] dataReaddata
);

  localparam int depth = 256;

  // Word arrays loaded by the testbench
  logic [31:0] instrMem [depth];
  logic [31:0] dataMem [depth];

  // Committed data writes since time 0
  int writeCount = 0;
  // Load strobes seen on enabled edges
  int readCount = 0;

  // Word index from the bits above the byte offset
  assign instrReaddata = instrMem[instrAddress[9:2]];
  assign dataReaddata  = dataMem[dataAddress[9:2]];

  // Stores land on the same edge that commits the instruction
  always @(posedge clk)
  begin
    if (!reset && clkEnable && dataWrite)
    begin
      dataMem[dataAddress[9:2]] <= dataWritedata;
      writeCount <= writeCount + 1;
    end
    if (!reset && clkEnable && dataRead)
      readCount <= readCount + 1;
  end

  // All zero words also decode as a nop
  task automatic clear();
    foreach (instrMem[i])
    begin
      instrMem[i] = 32'd0;
      dataMem[i]  = 32'd0;
    end
  endtask

endmodule

`default_nettype wire

//--- test/mipsCpuTb.sv
/*
  Directed testbench for the single-cycle Harvard MIPS core:
  clock, reset and watchdog, instruction encoders, program
  loader, one task per behavior with immediate assertion checks
*/
`default_nettype none

module mipsCpuTb import mipsPkg::*; ();

  localparam logic [31:0] resetVector = 32'hBFC00000;
  localparam int clkPeriod = 20;
  localparam int haltLimit = 200;
  localparam int numTests  = 6;
  // Budget doubled because two tests run their program twice
  localparam int watchdogTime = 2 * numTests * haltLimit * clkPeriod;

  logic        clk;
  logic        reset;
  logic        clkEnable;
  logic [31:0] instrAddress;
  logic [31:0] instrReaddata;
  logic [31:0] dataAddress;
  logic        dataRead;
  logic        dataWrite;
  logic [31:0] dataWritedata;
  logic [31:0] dataReaddata;
  logic        active;
  logic [31:0] registerV0;

  int          seed;
  int          errorCount;
  int          passCount;
  int          failCount;
  string       currentTest;
  logic [31:0] progWords [$];

  mipsCpuHarvard #(
    .resetVector (resetVector)
  ) mipsCpuHarvard_inst (
    .clk           (clk),
    .reset         (reset),
    .clkEnable     (clkEnable),
    .instrAddress  (instrAddress),
    .instrReaddata (instrReaddata),
    .dataAddress   (dataAddress),
    .dataRead      (dataRead),
    .dataWrite     (dataWrite),
    .dataWritedata (dataWritedata),
    .dataReaddata  (dataReaddata),
    .active        (active),
    .registerV0    (registerV0)
  );

  harvardMemModel harvardMemModel_inst (
    .clk           (clk),
    .reset         (reset),
    .clkEnable     (clkEnable),
    .instrAddress  (instrAddress),
    .instrReaddata (instrReaddata),
    .dataAddress   (dataAddress),
    .dataRead      (dataRead),
    .dataWrite     (dataWrite),
    .dataWritedata (dataWritedata),
    .dataReaddata  (dataReaddata)
  );

  initial
  begin
    clk = 1'b0;
    forever #(clkPeriod / 2) clk = ~clk;
  end

  // Watchdog
  initial
  begin
    #(watchdogTime);
    $display("Watchdog expired before all tests finished");
    $display("SOME TESTS FAILED");
    $finish;
  end

  // R-type encoder in assembler operand order rd, rs, rt
  function automatic logic [31:0] regOp(input functT fn, input logic [4:0] rd, rs, rt);
    return {opSpecial, rs, rt, rd, 5'd0, fn};
  endfunction

  function automatic logic [31:0] shiftOp(input functT fn, input logic [4:0] rd, rt, shamt);
    return {opSpecial, 5'd0, rt, rd, shamt, fn};
  endfunction

  // I-type encoder in operand order rt, rs, immediate
  function automatic logic [31:0] immOp(input opcodeT op, input logic [4:0] rt, rs,
                                        input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic logic [31:0] jumpOp(input opcodeT op, input logic [31:0] target);
    return {op, target[27:2]};
  endfunction

  // Byte address of program word k
  function automatic logic [31:0] instrAt(input int k);
    return resetVector + 32'(4 * k);
  endfunction

  // Unsigned 64-bit product by shift and add
  function automatic logic [63:0] shiftAddProduct(input logic [31:0] a, b);
    logic [63:0] acc;
    acc = 64'd0;
    for (int i = 0; i < 32; i++)
      if (b[i])
        acc = acc + ({32'd0, a} << i);
    return acc;
  endfunction

  task automatic emit(input logic [31:0] word);
    progWords.push_back(word);
  endtask

  // Full 32-bit constant through lui and ori
  task automatic loadConst(input logic [4:0] rt, input logic [31:0] value);
    emit(immOp(opLui, rt, 5'd0, value[31:16]));
    emit(immOp(opOri, rt, rt, value[15:0]));
  endtask

  // jr through $zero jumps to 0
  task automatic haltProgram();
    emit(regOp(fnJr, 5'd0, 5'd0, 5'd0));
  endtask

  task automatic loadProgram();
    harvardMemModel_inst.clear();
    foreach (progWords[i])
      harvardMemModel_inst.instrMem[resetVector[9:2] + i] = progWords[i];
    progWords.delete();
  endtask

  // Returns at the falling edge after reset is released
  task automatic applyReset();
    @(posedge clk);
    reset <= 1'b1;
    repeat (4) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
  endtask

  task automatic waitForHalt(output bit halted);
    int cycles;
    cycles = 0;
    while (active !== 1'b0 && cycles < haltLimit)
    begin
      @(negedge clk);
      cycles++;
    end
    halted = (active === 1'b0);
    if (!halted)
    begin
      $display("%s: active never fell within %0d cycles", currentTest, haltLimit);
      errorCount++;
    end
  endtask

  task automatic runProgram(output bit halted);
    loadProgram();
    applyReset();
    waitForHalt(halted);
  endtask

  task automatic checkValue(input string what, input logic [31:0] expected, actual);
    assert (actual === expected)
    else
    begin
      $display("Error: %s %s expected %h actual %h", currentTest, what, expected, actual);
      errorCount++;
    end
  endtask

  task automatic startTest(input string name);
    currentTest = name;
    errorCount  = 0;
  endtask

  task automatic finishTest();
    if (errorCount == 0)
    begin
      passCount++;
      $display("%s: passed", currentTest);
    end
    else
    begin
      failCount++;
      $display("%s: failed with %0d errors", currentTest, errorCount);
    end
  endtask

  task automatic resetAndHalt();
    bit halted;
    int writesAtStart;
    int writesAtHalt;
    startTest("resetAndHalt");
    // Word at index 0 is also what address 0 fetches
    emit(immOp(opSw, 5'd0, 5'd0, 16'h0040));
    emit(immOp(opAddiu, 5'd2, 5'd0, 16'h0001));
    haltProgram();
    loadProgram();
    applyReset();
    writesAtStart = harvardMemModel_inst.writeCount;
    checkValue("instrAddress after reset", resetVector, instrAddress);
    checkValue("active after reset", 32'd1, {31'd0, active});
    waitForHalt(halted);
    if (halted)
    begin
      writesAtHalt = harvardMemModel_inst.writeCount;
      checkValue("data writes before halt", writesAtStart + 1, writesAtHalt);
      repeat (10) @(negedge clk);
      checkValue("instrAddress after halt", 32'd0, instrAddress);
      checkValue("registerV0", 32'd1, registerV0);
      checkValue("data writes after halt", writesAtHalt, harvardMemModel_inst.writeCount);
    end
    finishTest();
  endtask

  task automatic arithmeticLogic();
    bit halted;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] sum;
    logic [31:0] mixed;
    logic [31:0] shifted;
    logic [31:0] flags;
    logic [31:0] expected;
    startTest("arithmeticLogic");
    a = $random(seed);
    b = $random(seed);
    loadConst(5'd8, a);
    loadConst(5'd9, b);
    emit(regOp(fnAddu, 5'd10, 5'd8, 5'd9));
    emit(regOp(fnSubu, 5'd11, 5'd8, 5'd9));
    emit(regOp(fnAnd, 5'd12, 5'd10, 5'd11));
    emit(regOp(fnXor, 5'd13, 5'd12, 5'd8));
    emit(regOp(fnSlt, 5'd14, 5'd8, 5'd9));
    emit(regOp(fnSltu, 5'd15, 5'd8, 5'd9));
    emit(shiftOp(fnSll, 5'd16, 5'd13, 5'd5));
    emit(shiftOp(fnSrl, 5'd17, 5'd10, 5'd7));
    emit(immOp(opAddiu, 5'd18, 5'd17, 16'hFF80));
    emit(regOp(fnAddu, 5'd19, 5'd16, 5'd18));
    emit(shiftOp(fnSll, 5'd20, 5'd15, 5'd1));
    emit(regOp(fnOr, 5'd21, 5'd14, 5'd20));
    emit(regOp(fnXor, 5'd2, 5'd19, 5'd21));
    haltProgram();
    // Same chain on the operands
    sum      = a + b;
    mixed    = (sum & (a - b)) ^ a;
    shifted  = (sum >> 7) - 32'd128;
    flags    = {31'd0, $signed(a) < $signed(b)} | {30'd0, a < b, 1'b0};
    expected = ((mixed << 5) + shifted) ^ flags;
    runProgram(halted);
    if (halted)
      checkValue("registerV0", expected, registerV0);
    finishTest();
  endtask

  task automatic loadStore();
    bit halted;
    int readsAtStart;
    logic [31:0] value;
    startTest("loadStore");
    value = $random(seed);
    loadConst(5'd8, value);
    emit(immOp(opAddiu, 5'd9, 5'd0, 16'h0100));
    emit(immOp(opSw, 5'd8, 5'd9, 16'h0004));
    emit(immOp(opLw, 5'd2, 5'd9, 16'h0004));
    haltProgram();
    readsAtStart = harvardMemModel_inst.readCount;
    runProgram(halted);
    if (halted)
    begin
      checkValue("data memory word", value, harvardMemModel_inst.dataMem[32'h104 >> 2]);
      checkValue("registerV0", value, registerV0);
      // Only the lw strobes dataRead
      checkValue("data read strobes", readsAtStart + 1, harvardMemModel_inst.readCount);
    end
    finishTest();
  endtask

  task automatic controlFlow();
    bit halted;
    startTest("controlFlow");
    emit(immOp(opAddiu, 5'd8, 5'd0, 16'd5));
    emit(immOp(opAddiu, 5'd9, 5'd0, 16'd5));
    emit(immOp(opAddiu, 5'd10, 5'd0, 16'd7));
    // Taken beq skips the next word
    emit(immOp(opBeq, 5'd9, 5'd8, 16'd1));
    emit(immOp(opAddiu, 5'd2, 5'd2, 16'd100));
    emit(immOp(opAddiu, 5'd2, 5'd2, 16'd1));
    emit(immOp(opBeq, 5'd10, 5'd8, 16'd1));
    emit(immOp(opAddiu, 5'd2, 5'd2, 16'd2));
    emit(immOp(opBne, 5'd10, 5'd8, 16'd1));
    emit(immOp(opAddiu, 5'd2, 5'd2, 16'd100));
    emit(immOp(opBne, 5'd9, 5'd8, 16'd1));
    emit(immOp(opAddiu, 5'd2, 5'd2, 16'd4));
    emit(jumpOp(opJ, instrAt(14)));
    emit(immOp(opAddiu, 5'd2, 5'd2, 16'd100));
    emit(jumpOp(opJal, instrAt(17)));
    emit(immOp(opAddiu, 5'd2, 5'd2, 16'd8));
    haltProgram();
    // Subroutine saves the link word, then returns
    emit(immOp(opAddiu, 5'd2, 5'd2, 16'd16));
    emit(immOp(opSw, 5'd31, 5'd0, 16'h0200));
    emit(regOp(fnJr, 5'd0, 5'd31, 5'd0));
    runProgram(halted);
    if (halted)
    begin
      checkValue("path count in registerV0", 32'd31, registerV0);
      checkValue("jal link address", instrAt(15), harvardMemModel_inst.dataMem[32'h200 >> 2]);
    end
    finishTest();
  endtask

  task automatic buildMultiply(input logic [31:0] a, b, input functT readFn);
    loadConst(5'd8, a);
    loadConst(5'd9, b);
    emit(regOp(fnMultu, 5'd0, 5'd8, 5'd9));
    emit(regOp(readFn, 5'd2, 5'd0, 5'd0));
    haltProgram();
  endtask

  task automatic multiplyHiLo();
    bit halted;
    logic [31:0] a;
    logic [31:0] b;
    logic [63:0] product;
    startTest("multiplyHiLo");
    a = $random(seed);
    b = $random(seed);
    product = shiftAddProduct(a, b);
    buildMultiply(a, b, fnMfhi);
    runProgram(halted);
    if (halted)
      checkValue("HI through registerV0", product[63:32], registerV0);
    buildMultiply(a, b, fnMflo);
    runProgram(halted);
    if (halted)
      checkValue("LO through registerV0", product[31:0], registerV0);
    finishTest();
  endtask

  task automatic buildStallProgram();
    emit(immOp(opAddiu, 5'd2, 5'd0, 16'd3));
    emit(immOp(opAddiu, 5'd8, 5'd0, 16'd10));
    emit(regOp(fnAddu, 5'd2, 5'd2, 5'd8));
    emit(shiftOp(fnSll, 5'd2, 5'd2, 5'd2));
    emit(immOp(opAddiu, 5'd2, 5'd2, 16'd7));
    haltProgram();
  endtask

  task automatic clockEnableStall();
    bit halted;
    logic [31:0] reference;
    logic [31:0] heldAddress;
    startTest("clockEnableStall");
    buildStallProgram();
    runProgram(halted);
    reference = registerV0;
    checkValue("registerV0 without stall", ((32'd3 + 32'd10) << 2) + 32'd7, reference);
    buildStallProgram();
    loadProgram();
    applyReset();
    // Two instructions commit, then the core stalls
    repeat (2) @(posedge clk);
    clkEnable <= 1'b0;
    @(negedge clk);
    heldAddress = instrAddress;
    checkValue("instrAddress at stall", instrAt(2), heldAddress);
    repeat (5)
    begin
      @(negedge clk);
      checkValue("instrAddress during stall", heldAddress, instrAddress);
    end
    @(posedge clk);
    clkEnable <= 1'b1;
    waitForHalt(halted);
    if (halted)
      checkValue("registerV0 after stall", reference, registerV0);
    finishTest();
  endtask

  initial
  begin
    reset     = 1'b1;
    clkEnable = 1'b1;
    seed      = 87516;
    passCount = 0;
    failCount = 0;
    resetAndHalt();
    arithmeticLogic();
    loadStore();
    controlFlow();
    multiplyHiLo();
    clockEnableStall();
    $display("Tests run %0d, passed %0d, failed %0d", passCount + failCount, passCount,
             failCount);
    if (failCount == 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire
